// ==== llc_cfg_top.f ====
verilog/llc_cfg_pkg.sv
verilog/llc_cfg_axil_req.sv
verilog/llc_cfg_regbank.sv
verilog/llc_cfg_axil_resp.sv
verilog/llc_cfg_top.sv
bench/llc_cfg_assertions.sv
bench/llc_cfg_tb.sv

// ==== bench/llc_cfg_tb.sv ====
/* Testbench that runs random AXI4-Lite traffic and cache events into the LLC
   configuration block under B/R back-pressure and checks a register model */
`timescale 1ns/1ps

module llc_cfg_tb;

  localparam int WinW      = 64;
  localparam int NumWin    = 16;
  localparam int NumMixed  = 24;
  localparam int EvtCycles = 40;
  localparam int NumTxn    = 7 + 2 * NumWin + 23 + 16 + 8 + 2 * NumMixed;
  localparam int TxnBound  = 40;
  localparam llc_cfg_pkg::axil_addr_t RegAddr [7] = '{
    llc_cfg_pkg::RegCacheStart, llc_cfg_pkg::RegCacheEnd, llc_cfg_pkg::RegSpmStart,
    llc_cfg_pkg::RegReadHit, llc_cfg_pkg::RegReadMiss, llc_cfg_pkg::RegWriteHit,
    llc_cfg_pkg::RegWriteMiss};

  logic                     clk_i = 1'b0;
  logic                     reset_i;
  logic                     awvalid_i;
  llc_cfg_pkg::axil_addr_t  awaddr_i;
  logic                     awready_o;
  logic                     wvalid_i;
  llc_cfg_pkg::axil_data_t  wdata_i;
  logic                     wready_o;
  logic                     bvalid_o;
  llc_cfg_pkg::axil_resp_t  bresp_o;
  logic                     bready_i;
  logic                     arvalid_i;
  llc_cfg_pkg::axil_addr_t  araddr_i;
  logic                     arready_o;
  logic                     rvalid_o;
  llc_cfg_pkg::axil_data_t  rdata_o;
  llc_cfg_pkg::axil_resp_t  rresp_o;
  logic                     rready_i;
  llc_cfg_pkg::llc_events_t llc_events_i;
  logic [WinW-1:0]          cache_start_o;
  logic [WinW-1:0]          cache_end_o;
  logic [WinW-1:0]          spm_start_o;

  // Model slots 0 to 2 hold the windows and 3 to 6 the counters
  llc_cfg_pkg::axil_data_t model_q [7];
  llc_cfg_pkg::axil_resp_t exp_b [$];
  llc_cfg_pkg::cfg_rsp_t   exp_r [$];
  logic [31:0]             rnd_state;
  logic [31:0]             stall_state = 32'h5309_ee87;
  string                   test_name;

  llc_cfg_top #(.WinAddrWidth(WinW)) llc_cfg_top_i (.*);

  bind llc_cfg_top llc_cfg_assertions assertions_i (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper LCG bits are the better ones
  function automatic logic [31:0] rand32();
    rnd_state = lcg_next(rnd_state);
    return {rnd_state[15:0], rnd_state[31:16]};
  endfunction

  function automatic int slot_of(input llc_cfg_pkg::axil_addr_t addr);
    for (int i = 0; i < 7; i++) begin
      if (addr == RegAddr[i]) return i;
    end
    return -1;
  endfunction

  task automatic value_error(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    $display("** Error %s: %s expected %h actual %h", test_name, what, exp_v, act_v);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic plain_error(input string msg);
    $display("%s: %s", test_name, msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic write_reg(input llc_cfg_pkg::axil_addr_t addr,
                           input llc_cfg_pkg::axil_data_t data);
    bit aw_done;
    bit w_done;
    int slot;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(posedge clk_i);
    awvalid_i <= 1'b1;
    awaddr_i  <= addr;
    wvalid_i  <= 1'b1;
    wdata_i   <= data;
    while (!(aw_done && w_done)) begin
      @(negedge clk_i);
      aw_done = aw_done | awready_o;
      w_done  = w_done | wready_o;
      @(posedge clk_i);
      if (aw_done) awvalid_i <= 1'b0;
      if (w_done) wvalid_i <= 1'b0;
    end
    slot = slot_of(addr);
    exp_b.push_back(slot < 0 ? llc_cfg_pkg::RespSlvErr : llc_cfg_pkg::RespOkay);
    if (slot >= 0) model_q[slot] = (slot < 3) ? data : '0;
  endtask

  task automatic read_reg(input llc_cfg_pkg::axil_addr_t addr);
    bit                    done;
    int                    slot;
    llc_cfg_pkg::cfg_rsp_t exp_rsp;
    done = 1'b0;
    @(posedge clk_i);
    arvalid_i <= 1'b1;
    araddr_i  <= addr;
    while (!done) begin
      @(negedge clk_i);
      done = arready_o;
      @(posedge clk_i);
    end
    arvalid_i <= 1'b0;
    slot = slot_of(addr);
    exp_rsp.is_write = 1'b0;
    exp_rsp.rdata    = (slot < 0) ? '0 : model_q[slot];
    exp_rsp.resp     = (slot < 0) ? llc_cfg_pkg::RespSlvErr : llc_cfg_pkg::RespOkay;
    exp_r.push_back(exp_rsp);
  endtask

  task automatic count_events(input int cycles);
    logic [31:0]              bits;
    llc_cfg_pkg::llc_events_t ev;
    for (int c = 0; c < cycles; c++) begin
      bits = rand32();
      ev   = bits[3:0];
      @(posedge clk_i);
      llc_events_i <= ev;
      model_q[3] += 32'(ev.read_hit);
      model_q[4] += 32'(ev.read_miss);
      model_q[5] += 32'(ev.write_hit);
      model_q[6] += 32'(ev.write_miss);
    end
    @(posedge clk_i);
    llc_events_i <= '0;
  endtask

  task automatic wait_idle();
    while (exp_b.size() != 0 || exp_r.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic check_windows();
    assert (cache_start_o == WinW'(model_q[0]))
      else value_error("cache_start_o", WinW'(model_q[0]), cache_start_o);
    assert (cache_end_o == WinW'(model_q[1]))
      else value_error("cache_end_o", WinW'(model_q[1]), cache_end_o);
    assert (spm_start_o == WinW'(model_q[2]))
      else value_error("spm_start_o", WinW'(model_q[2]), spm_start_o);
  endtask

  // Random back-pressure on both response channels
  always @(posedge clk_i) begin
    stall_state <= lcg_next(stall_state);
    bready_i    <= stall_state[27] | stall_state[29];
    rready_i    <= stall_state[26] | stall_state[30];
  end

  // Responses are checked in order per channel
  always @(negedge clk_i) begin
    if (bvalid_o && bready_i) begin
      assert (exp_b.size() != 0) else plain_error("write response with no write outstanding");
      assert (bresp_o == exp_b[0]) else value_error("bresp", exp_b[0], bresp_o);
      void'(exp_b.pop_front());
    end
    if (rvalid_o && rready_i) begin
      assert (exp_r.size() != 0) else plain_error("read response with no read outstanding");
      assert (rresp_o == exp_r[0].resp) else value_error("rresp", exp_r[0].resp, rresp_o);
      assert (rdata_o == exp_r[0].rdata) else value_error("rdata", exp_r[0].rdata, rdata_o);
      void'(exp_r.pop_front());
    end
  end

  initial begin
    #((NumTxn * TxnBound + 4 * EvtCycles + 20) * 8);
    $display("%s: watchdog expired before all transactions completed", test_name);
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  initial begin
    llc_cfg_pkg::axil_data_t data;
    llc_cfg_pkg::axil_addr_t addr;
    int                      idx;
    reset_i      = 1'b1;
    awvalid_i    = 1'b0;
    awaddr_i     = '0;
    wvalid_i     = 1'b0;
    wdata_i      = '0;
    arvalid_i    = 1'b0;
    araddr_i     = '0;
    bready_i     = 1'b0;
    rready_i     = 1'b0;
    llc_events_i = '0;
    rnd_state    = 32'h5309_ee87;
    model_q      = '{default: '0};
    test_name    = "reset";
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    assert (!bvalid_o && !rvalid_o) else plain_error("response valid high after reset");
    for (int i = 0; i < 7; i++) read_reg(RegAddr[i]);
    wait_idle();

    test_name = "window";
    for (int n = 0; n < NumWin; n++) begin
      idx  = rand32() % 3;
      data = rand32();
      write_reg(RegAddr[idx], data);
      wait_idle();
      read_reg(RegAddr[idx]);
      wait_idle();
      check_windows();
    end

    test_name = "unmapped";
    for (int n = 0; n < 8; n++) begin
      addr = (n == 0) ? 32'h0000_000C : (rand32() | 32'h20) & 32'hFFFF_FFFC;
      write_reg(addr, rand32());
      read_reg(addr);
      wait_idle();
    end
    for (int i = 0; i < 7; i++) read_reg(RegAddr[i]);
    wait_idle();

    test_name = "counters";
    for (int r = 0; r < 4; r++) begin
      count_events(EvtCycles);
      for (int i = 3; i < 7; i++) read_reg(RegAddr[i]);
      wait_idle();
    end

    test_name = "clear";
    for (int i = 3; i < 7; i++) begin
      write_reg(RegAddr[i], rand32());
      read_reg(RegAddr[i]);
    end
    wait_idle();

    // Writers touch only windows 0 and 1 so the reads stay predictable
    test_name = "stall";
    fork
      for (int n = 0; n < NumMixed; n++) begin
        data = rand32();
        write_reg(data[9] ? 32'h0000_0040 : RegAddr[data[8]], data);
      end
      for (int n = 0; n < NumMixed; n++) begin
        read_reg((n % 6 == 5) ? 32'h0000_000C : RegAddr[2 + n % 6]);
      end
    join
    wait_idle();
    check_windows();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== bench/llc_cfg_assertions.sv ====
/* Protocol checks on the AXI4-Lite response channels and ready signals,
   bound into the LLC configuration block by the testbench */
`timescale 1ns/1ps

module llc_cfg_assertions (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    awready_o,
  input logic                    wready_o,
  input logic                    arready_o,
  input logic                    bvalid_o,
  input llc_cfg_pkg::axil_resp_t bresp_o,
  input logic                    bready_i,
  input logic                    rvalid_o,
  input llc_cfg_pkg::axil_data_t rdata_o,
  input llc_cfg_pkg::axil_resp_t rresp_o,
  input logic                    rready_i
);

  // Responses stay put until taken
  b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
    else $error("B response dropped or changed before bready");

  r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
    else $error("R response dropped or changed before rready");

  one_resp: assert property (@(posedge clk_i) disable iff (reset_i) !(bvalid_o && rvalid_o))
    else $error("bvalid and rvalid high together");

  ready_after_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |-> awready_o && wready_o && arready_o)
    else $error("A ready is low in the first cycle after reset");

endmodule

// ==== verilog/llc_cfg_top.sv ====
/* AXI4-Lite slave holding the LLC address window registers and cache event
   counters and driving the windows out at the cache address width */
`timescale 1ns/1ps

module llc_cfg_top #(
  parameter int unsigned WinAddrWidth = 64
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     awvalid_i,
  input  llc_cfg_pkg::axil_addr_t  awaddr_i,
  output logic                     awready_o,
  input  logic                     wvalid_i,
  input  llc_cfg_pkg::axil_data_t  wdata_i,
  output logic                     wready_o,
  output logic                     bvalid_o,
  output llc_cfg_pkg::axil_resp_t  bresp_o,
  input  logic                     bready_i,
  input  logic                     arvalid_i,
  input  llc_cfg_pkg::axil_addr_t  araddr_i,
  output logic                     arready_o,
  output logic                     rvalid_o,
  output llc_cfg_pkg::axil_data_t  rdata_o,
  output llc_cfg_pkg::axil_resp_t  rresp_o,
  input  logic                     rready_i,
  input  llc_cfg_pkg::llc_events_t llc_events_i,
  output logic [WinAddrWidth-1:0]  cache_start_o,
  output logic [WinAddrWidth-1:0]  cache_end_o,
  output logic [WinAddrWidth-1:0]  spm_start_o
);

  logic                  req_valid;
  llc_cfg_pkg::cfg_req_t req;
  llc_cfg_pkg::cfg_rsp_t rsp;
  logic                  slot_free;

  llc_cfg_axil_req i_axil_req (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .awvalid_i   ( awvalid_i ),
    .awaddr_i    ( awaddr_i  ),
    .awready_o   ( awready_o ),
    .wvalid_i    ( wvalid_i  ),
    .wdata_i     ( wdata_i   ),
    .wready_o    ( wready_o  ),
    .arvalid_i   ( arvalid_i ),
    .araddr_i    ( araddr_i  ),
    .arready_o   ( arready_o ),
    .slot_free_i ( slot_free ),
    .req_valid_o ( req_valid ),
    .req_o       ( req       )
  );

  llc_cfg_regbank #(
    .WinAddrWidth ( WinAddrWidth )
  ) i_regbank (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .req_valid_i   ( req_valid     ),
    .req_i         ( req           ),
    .llc_events_i  ( llc_events_i  ),
    .rsp_o         ( rsp           ),
    .cache_start_o ( cache_start_o ),
    .cache_end_o   ( cache_end_o   ),
    .spm_start_o   ( spm_start_o   )
  );

  llc_cfg_axil_resp i_axil_resp (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .req_valid_i ( req_valid ),
    .rsp_i       ( rsp       ),
    .slot_free_o ( slot_free ),
    .bvalid_o    ( bvalid_o  ),
    .bresp_o     ( bresp_o   ),
    .bready_i    ( bready_i  ),
    .rvalid_o    ( rvalid_o  ),
    .rdata_o     ( rdata_o   ),
    .rresp_o     ( rresp_o   ),
    .rready_i    ( rready_i  )
  );

endmodule

// ==== verilog/llc_cfg_axil_resp.sv ====
/* AXI4-Lite response side with one slot that holds a B or R response until
   the master takes it and tells the request side when it is free */
`timescale 1ns/1ps

module llc_cfg_axil_resp (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_valid_i,
  input  llc_cfg_pkg::cfg_rsp_t   rsp_i,
  output logic                    slot_free_o,
  output logic                    bvalid_o,
  output llc_cfg_pkg::axil_resp_t bresp_o,
  input  logic                    bready_i,
  output logic                    rvalid_o,
  output llc_cfg_pkg::axil_data_t rdata_o,
  output llc_cfg_pkg::axil_resp_t rresp_o,
  input  logic                    rready_i
);

  logic                    full_q;
  logic                    is_write_q;
  llc_cfg_pkg::axil_resp_t resp_q;
  llc_cfg_pkg::axil_data_t rdata_q;
  logic                    taken;

  assign slot_free_o = ~full_q;

  assign bvalid_o = full_q & is_write_q;
  assign rvalid_o = full_q & ~is_write_q;
  assign bresp_o  = resp_q;
  assign rresp_o  = resp_q;
  assign rdata_o  = rdata_q;

  assign taken = (bvalid_o & bready_i) | (rvalid_o & rready_i);

  // Loaded only while empty since the request side checks slot_free
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (req_valid_i) begin
      full_q <= 1'b1;
    end else if (taken) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      is_write_q <= rsp_i.is_write;
      resp_q     <= rsp_i.resp;
    end
    // Read data only from a read result
    if (req_valid_i && !rsp_i.is_write) begin
      rdata_q <= rsp_i.rdata;
    end
  end

endmodule

// ==== verilog/llc_cfg_regbank.sv ====
/* Window registers and cache event counters of the LLC configuration block.
   Decodes one access per cycle and answers it combinationally */
`timescale 1ns/1ps

module llc_cfg_regbank #(
  parameter int unsigned WinAddrWidth = 64
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          req_valid_i,
  input  llc_cfg_pkg::cfg_req_t         req_i,
  input  llc_cfg_pkg::llc_events_t      llc_events_i,
  output llc_cfg_pkg::cfg_rsp_t         rsp_o,
  output logic [WinAddrWidth-1:0]       cache_start_o,
  output logic [WinAddrWidth-1:0]       cache_end_o,
  output logic [WinAddrWidth-1:0]       spm_start_o
);

  typedef llc_cfg_pkg::reg_idx_t reg_idx_t;

  localparam reg_idx_t IdxCacheStart = reg_idx_t'(llc_cfg_pkg::RegCacheStart >> 2);
  localparam reg_idx_t IdxCacheEnd   = reg_idx_t'(llc_cfg_pkg::RegCacheEnd >> 2);
  localparam reg_idx_t IdxSpmStart   = reg_idx_t'(llc_cfg_pkg::RegSpmStart >> 2);
  localparam reg_idx_t IdxReadHit    = reg_idx_t'(llc_cfg_pkg::RegReadHit >> 2);
  localparam reg_idx_t IdxReadMiss   = reg_idx_t'(llc_cfg_pkg::RegReadMiss >> 2);
  localparam reg_idx_t IdxWriteHit   = reg_idx_t'(llc_cfg_pkg::RegWriteHit >> 2);
  localparam reg_idx_t IdxWriteMiss  = reg_idx_t'(llc_cfg_pkg::RegWriteMiss >> 2);

  llc_cfg_pkg::axil_data_t win_q [3];
  llc_cfg_pkg::axil_data_t cnt_q [4];

  reg_idx_t                idx;
  logic                    in_range;
  logic                    hit;
  logic                    mapped;
  logic                    wr_en;
  logic [2:0]              win_sel;
  logic [3:0]              cnt_sel;
  logic [3:0]              evt_vec;
  llc_cfg_pkg::axil_data_t rd_val;

  assign idx      = req_i.addr[4:2];
  assign in_range = (req_i.addr[31:5] == '0) && (req_i.addr[1:0] == 2'b00);
  assign mapped   = in_range & hit;
  assign wr_en    = req_valid_i & req_i.is_write & mapped;

  // Counter slot 0 is read hit
  assign evt_vec = {llc_events_i.write_miss, llc_events_i.write_hit,
                    llc_events_i.read_miss, llc_events_i.read_hit};

  always_comb begin
    hit     = 1'b1;
    win_sel = '0;
    cnt_sel = '0;
    rd_val  = '0;
    case (idx)
      IdxCacheStart: win_sel = 3'b001;
      IdxCacheEnd:   win_sel = 3'b010;
      IdxSpmStart:   win_sel = 3'b100;
      IdxReadHit:    cnt_sel = 4'b0001;
      IdxReadMiss:   cnt_sel = 4'b0010;
      IdxWriteHit:   cnt_sel = 4'b0100;
      IdxWriteMiss:  cnt_sel = 4'b1000;
      default:       hit     = 1'b0;
    endcase
    for (int i = 0; i < 3; i++) begin
      if (win_sel[i]) rd_val = win_q[i];
    end
    for (int i = 0; i < 4; i++) begin
      if (cnt_sel[i]) rd_val = cnt_q[i];
    end
  end

  assign rsp_o.is_write = req_i.is_write;
  assign rsp_o.rdata    = (mapped && !req_i.is_write) ? rd_val : '0;
  assign rsp_o.resp     = mapped ? llc_cfg_pkg::RespOkay : llc_cfg_pkg::RespSlvErr;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 3; i++) win_q[i] <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (wr_en && win_sel[i]) win_q[i] <= req_i.wdata;
      end
    end
  end

  // Clear by write wins over a same cycle event
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 4; i++) cnt_q[i] <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (wr_en && cnt_sel[i]) begin
          cnt_q[i] <= '0;
        end else if (evt_vec[i]) begin
          cnt_q[i] <= cnt_q[i] + 32'd1;
        end
      end
    end
  end

  assign cache_start_o = WinAddrWidth'(win_q[0]);
  assign cache_end_o   = WinAddrWidth'(win_q[1]);
  assign spm_start_o   = WinAddrWidth'(win_q[2]);

endmodule

// ==== verilog/llc_cfg_axil_req.sv ====
/* AXI4-Lite request side that holds AW, W and AR and issues one register
   access at a time with writes first while the response slot is free */
`timescale 1ns/1ps

module llc_cfg_axil_req (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    awvalid_i,
  input  llc_cfg_pkg::axil_addr_t awaddr_i,
  output logic                    awready_o,
  input  logic                    wvalid_i,
  input  llc_cfg_pkg::axil_data_t wdata_i,
  output logic                    wready_o,
  input  logic                    arvalid_i,
  input  llc_cfg_pkg::axil_addr_t araddr_i,
  output logic                    arready_o,
  input  logic                    slot_free_i,
  output logic                    req_valid_o,
  output llc_cfg_pkg::cfg_req_t   req_o
);

  logic                    aw_full_q;
  logic                    w_full_q;
  logic                    ar_full_q;
  llc_cfg_pkg::axil_addr_t aw_addr_q;
  llc_cfg_pkg::axil_data_t w_data_q;
  llc_cfg_pkg::axil_addr_t ar_addr_q;

  logic wr_pending;
  logic issue_wr;
  logic issue_rd;

  // A holder takes new data only while empty
  assign awready_o = ~aw_full_q;
  assign wready_o  = ~w_full_q;
  assign arready_o = ~ar_full_q;

  // Write needs both halves and beats a waiting read
  assign wr_pending = aw_full_q & w_full_q;
  assign issue_wr   = slot_free_i & wr_pending;
  assign issue_rd   = slot_free_i & ~wr_pending & ar_full_q;

  assign req_valid_o    = issue_wr | issue_rd;
  assign req_o.is_write = wr_pending;
  assign req_o.addr     = wr_pending ? aw_addr_q : ar_addr_q;
  assign req_o.wdata    = w_data_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_full_q <= 1'b0;
      w_full_q  <= 1'b0;
      ar_full_q <= 1'b0;
    end else begin
      if (issue_wr) begin
        aw_full_q <= 1'b0;
        w_full_q  <= 1'b0;
      end else begin
        if (awvalid_i && awready_o) aw_full_q <= 1'b1;
        if (wvalid_i && wready_o)   w_full_q  <= 1'b1;
      end
      if (issue_rd) begin
        ar_full_q <= 1'b0;
      end else if (arvalid_i && arready_o) begin
        ar_full_q <= 1'b1;
      end
    end
  end

  // Payloads
  always_ff @(posedge clk_i) begin
    if (awvalid_i && awready_o) aw_addr_q <= awaddr_i;
    if (wvalid_i && wready_o)   w_data_q  <= wdata_i;
    if (arvalid_i && arready_o) ar_addr_q <= araddr_i;
  end

endmodule

// ==== verilog/llc_cfg_pkg.sv ====
/* Widths, register map, response codes and request/response structs that
   the LLC configuration block RTL and its testbench share */
package llc_cfg_pkg;

  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  // Word index within the block, address bits 4 to 2
  typedef logic [2:0]  reg_idx_t;

  localparam axil_resp_t RespOkay   = 2'd0;
  localparam axil_resp_t RespSlvErr = 2'd2;

  // Address windows
  localparam axil_addr_t RegCacheStart = 32'h0000_0000;
  localparam axil_addr_t RegCacheEnd   = 32'h0000_0004;
  localparam axil_addr_t RegSpmStart   = 32'h0000_0008;

  // Event counters that a write clears
  localparam axil_addr_t RegReadHit    = 32'h0000_0010;
  localparam axil_addr_t RegReadMiss   = 32'h0000_0014;
  localparam axil_addr_t RegWriteHit   = 32'h0000_0018;
  localparam axil_addr_t RegWriteMiss  = 32'h0000_001C;

  typedef struct packed {
    logic read_hit;
    logic read_miss;
    logic write_hit;
    logic write_miss;
  } llc_events_t;

  // One register access from the input side
  typedef struct packed {
    logic       is_write;
    axil_addr_t addr;
    axil_data_t wdata;
  } cfg_req_t;

  // Result of that access
  typedef struct packed {
    logic       is_write;
    axil_data_t rdata;
    axil_resp_t resp;
  } cfg_rsp_t;

endpackage
